/* common/cache_pkg.sv */
`default_nettype none

package cache_pkg;

  localparam int ADDR_W = 8;
  localparam int DATA_W = 16;
  localparam int INDEX_W = 2;
  localparam int TAG_W = ADDR_W - INDEX_W;
  localparam int NUM_LINES = 1 << INDEX_W;  // direct mapped, one word per line.
  localparam int MEM_WORDS = 1 << ADDR_W;

  localparam int READ_LATENCY = 9;
  localparam int WRITE_LATENCY = 14;
  localparam int MIN_HIT_CYCLES = 5;
  localparam int MIN_MISS_CYCLES = 7;
  localparam int LAT_CNT_W = 4;  // wide enough for the longest memory wait.

  typedef logic [ADDR_W-1:0] addr_t;  // tag in the high bits, index in the low bits.
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [LAT_CNT_W-1:0] lat_cnt_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    DECIDE,
    FILL_REQ,
    MEM_ISSUE,
    MEM_WAIT,
    FILL_DONE,
    FINISH
  } ctrl_state_t;

endpackage

`default_nettype wire

/* common/mem_if.sv */
`default_nettype none

interface mem_if;

  logic req_valid;  // single cycle request strobe.
  logic req_write;
  cache_pkg::addr_t req_addr;
  cache_pkg::data_t req_wdata;

  logic ready;  // low while the memory is busy.
  logic rsp_valid;  // single cycle completion pulse.
  cache_pkg::data_t rsp_rdata;

  modport ctrl (
    output req_valid,
    output req_write,
    output req_addr,
    output req_wdata,
    input  ready,
    input  rsp_valid,
    input  rsp_rdata
  );

  modport mem (
    input  req_valid,
    input  req_write,
    input  req_addr,
    input  req_wdata,
    output ready,
    output rsp_valid,
    output rsp_rdata
  );

endinterface

`default_nettype wire

/* common/array_if.sv */
`default_nettype none

interface array_if;

  cache_pkg::index_t index;
  cache_pkg::tag_t tag;
  logic wr_en;  // stores wdata at index on the clock edge.
  cache_pkg::data_t wdata;
  logic alloc;  // marks the line at index valid with tag.

  logic hit;  // combinational from index and tag.
  cache_pkg::data_t rdata;

  modport ctrl (
    output index,
    output tag,
    output wr_en,
    output wdata,
    output alloc,
    input  hit,
    input  rdata
  );

  modport array (
    input  index,
    input  tag,
    input  wr_en,
    input  wdata,
    input  alloc,
    output hit,
    output rdata
  );

endinterface

`default_nettype wire

/* cache/cache_array.sv */
`default_nettype none

module cache_array (
  input wire logic clk_i,
  input wire logic reset_n_i,
  array_if.array   arr
);

  cache_pkg::tag_t tag_q [cache_pkg::NUM_LINES];
  cache_pkg::data_t data_q [cache_pkg::NUM_LINES];
  logic [cache_pkg::NUM_LINES-1:0] valid_q;

  // lookup is purely combinational on the presented index and tag.
  assign arr.hit = valid_q[arr.index] && (tag_q[arr.index] == arr.tag);
  assign arr.rdata = data_q[arr.index];

  always_ff @(posedge clk_i or negedge reset_n_i) begin
    if (!reset_n_i) begin
      valid_q <= '0;
      for (int i = 0; i < cache_pkg::NUM_LINES; i++) begin
        tag_q[i] <= '0;
        data_q[i] <= '0;
      end
    end else begin
      if (arr.wr_en) begin
        data_q[arr.index] <= arr.wdata;
      end
      if (arr.alloc) begin
        tag_q[arr.index] <= arr.tag;  // any older line at this index is evicted.
        valid_q[arr.index] <= 1'b1;
      end
    end
  end

  // the controller keeps the address steady through FILL_DONE.
  alloc_then_hit: assert property (@(posedge clk_i) disable iff (!reset_n_i)
    arr.alloc |=> arr.hit);

endmodule

`default_nettype wire

/* cache/cache_ctrl.sv */
`default_nettype none

module cache_ctrl (
  input  wire logic             clk_i,
  input  wire logic             reset_n_i,
  input  wire cache_pkg::addr_t address_i,
  input  wire logic             address_valid_i,
  input  wire cache_pkg::data_t write_data_i,
  input  wire logic             write_data_valid_i,
  input  wire logic             write_i,
  output cache_pkg::data_t      read_data_o,
  output logic                  read_data_valid_o,
  output logic                  write_done_o,
  output logic                  port_ready_o,
  output logic                  hit_o,
  array_if.ctrl                 arr,
  mem_if.ctrl                   mem
);

  cache_pkg::ctrl_state_t state_q;
  cache_pkg::lat_cnt_t lat_cnt_q;
  cache_pkg::addr_t addr_q;
  cache_pkg::data_t wdata_q;
  cache_pkg::data_t read_data_q;
  cache_pkg::addr_t req_addr_q;
  cache_pkg::data_t req_wdata_q;
  logic write_q;
  logic hit_q;
  logic req_valid_q;
  logic req_write_q;
  logic rd_valid_q;
  logic wr_done_q;
  logic ready_q;
  logic accept;
  logic floor_met;
  logic fill_ret;

  assign accept = ready_q && address_valid_i && (!write_i || write_data_valid_i);
  assign floor_met = hit_q ? (lat_cnt_q >= cache_pkg::lat_cnt_t'(cache_pkg::MIN_HIT_CYCLES))
                           : (lat_cnt_q >= cache_pkg::lat_cnt_t'(cache_pkg::MIN_MISS_CYCLES));
  assign fill_ret = (state_q == cache_pkg::MEM_WAIT) && mem.rsp_valid && !write_q;

  assign arr.index = addr_q[cache_pkg::INDEX_W-1:0];
  assign arr.tag = addr_q[cache_pkg::ADDR_W-1:cache_pkg::INDEX_W];
  assign arr.wr_en = ((state_q == cache_pkg::DECIDE) && hit_q && write_q) || fill_ret;
  assign arr.alloc = fill_ret;  // tag and valid follow the returned word.
  assign arr.wdata = fill_ret ? mem.rsp_rdata : wdata_q;

  assign mem.req_valid = req_valid_q;
  assign mem.req_write = req_write_q;
  assign mem.req_addr = req_addr_q;
  assign mem.req_wdata = req_wdata_q;

  assign read_data_o = read_data_q;
  assign read_data_valid_o = rd_valid_q;
  assign write_done_o = wr_done_q;
  assign port_ready_o = ready_q;
  assign hit_o = hit_q;

  always_ff @(posedge clk_i or negedge reset_n_i) begin
    if (!reset_n_i) begin
      state_q <= cache_pkg::IDLE;
      lat_cnt_q <= '0;
      write_q <= 1'b0;
      hit_q <= 1'b0;
      req_valid_q <= 1'b0;
      req_write_q <= 1'b0;
      rd_valid_q <= 1'b0;
      wr_done_q <= 1'b0;
      ready_q <= 1'b1;
    end else begin
      if ((state_q != cache_pkg::IDLE) && (lat_cnt_q != '1)) begin
        lat_cnt_q <= lat_cnt_q + 1'b1;  // saturates on long memory waits.
      end
      req_valid_q <= 1'b0;
      case (state_q)
        cache_pkg::IDLE: begin
          if (accept) begin
            state_q <= cache_pkg::LOOKUP;
            write_q <= write_i;
            ready_q <= 1'b0;
            rd_valid_q <= 1'b0;
            wr_done_q <= 1'b0;
            lat_cnt_q <= cache_pkg::lat_cnt_t'(1);
          end
        end
        cache_pkg::LOOKUP: begin
          hit_q <= arr.hit;
          state_q <= cache_pkg::DECIDE;
        end
        cache_pkg::DECIDE: begin
          if (write_q) begin
            req_write_q <= 1'b1;  // write-through on hit and miss alike.
            state_q <= cache_pkg::MEM_ISSUE;
          end else if (hit_q) begin
            state_q <= cache_pkg::FINISH;
          end else begin
            state_q <= cache_pkg::FILL_REQ;
          end
        end
        cache_pkg::FILL_REQ: begin
          req_write_q <= 1'b0;
          state_q <= cache_pkg::MEM_ISSUE;
        end
        cache_pkg::MEM_ISSUE: begin
          if (mem.ready) begin
            req_valid_q <= 1'b1;
            state_q <= cache_pkg::MEM_WAIT;
          end
        end
        cache_pkg::MEM_WAIT: begin
          if (mem.rsp_valid) begin
            state_q <= write_q ? cache_pkg::FINISH : cache_pkg::FILL_DONE;
          end
        end
        cache_pkg::FILL_DONE: begin
          state_q <= cache_pkg::FINISH;
        end
        cache_pkg::FINISH: begin
          if (floor_met) begin
            rd_valid_q <= !write_q;
            wr_done_q <= write_q;
            ready_q <= 1'b1;
            lat_cnt_q <= '0;
            state_q <= cache_pkg::IDLE;
          end
        end
        default: begin
          state_q <= cache_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= address_i;
      wdata_q <= write_data_i;
    end
    if ((state_q == cache_pkg::DECIDE) && hit_q && !write_q) begin
      read_data_q <= arr.rdata;
    end
    if (state_q == cache_pkg::FILL_DONE) begin
      read_data_q <= arr.rdata;  // the line was filled on the previous edge.
    end
    if ((state_q == cache_pkg::DECIDE) || (state_q == cache_pkg::FILL_REQ)) begin
      req_addr_q <= addr_q;
      req_wdata_q <= wdata_q;
    end
  end

  ready_in_idle: assert property (@(posedge clk_i) disable iff (!reset_n_i)
    port_ready_o == (state_q == cache_pkg::IDLE));

  req_only_when_ready: assert property (@(posedge clk_i) disable iff (!reset_n_i)
    mem.req_valid |-> mem.ready);

  one_done_flag: assert property (@(posedge clk_i) disable iff (!reset_n_i)
    !(read_data_valid_o && write_done_o));

endmodule

`default_nettype wire

/* verilog/backing_memory.sv */
`default_nettype none

module backing_memory (
  input wire logic clk_i,
  input wire logic reset_n_i,
  mem_if.mem       mem
);

  cache_pkg::data_t mem_q [cache_pkg::MEM_WORDS];
  cache_pkg::lat_cnt_t wait_q;
  cache_pkg::addr_t addr_q;
  cache_pkg::data_t wdata_q;
  cache_pkg::data_t rdata_q;
  logic busy_q;
  logic write_q;
  logic rsp_valid_q;
  logic done;

  assign done = busy_q && (wait_q == '0);

  assign mem.ready = !busy_q;
  assign mem.rsp_valid = rsp_valid_q;
  assign mem.rsp_rdata = rdata_q;

  always_ff @(posedge clk_i or negedge reset_n_i) begin
    if (!reset_n_i) begin
      wait_q <= '0;
      busy_q <= 1'b0;
      write_q <= 1'b0;
      rsp_valid_q <= 1'b0;
      for (int i = 0; i < cache_pkg::MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      rsp_valid_q <= 1'b0;
      if (mem.req_valid) begin
        busy_q <= 1'b1;
        write_q <= mem.req_write;
        wait_q <= mem.req_write ? cache_pkg::lat_cnt_t'(cache_pkg::WRITE_LATENCY)
                                : cache_pkg::lat_cnt_t'(cache_pkg::READ_LATENCY);
      end else if (busy_q) begin
        if (wait_q != '0) begin
          wait_q <= wait_q - 1'b1;
        end else begin
          busy_q <= 1'b0;  // ready rises with the response pulse.
          rsp_valid_q <= 1'b1;
          if (write_q) begin
            mem_q[addr_q] <= wdata_q;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem.req_valid) begin
      addr_q <= mem.req_addr;
      wdata_q <= mem.req_wdata;
    end
    if (done && !write_q) begin
      rdata_q <= mem_q[addr_q];
    end
  end

  // a request is taken without looking at busy, so the controller must wait.
  no_req_when_busy: assert property (@(posedge clk_i) disable iff (!reset_n_i)
    mem.req_valid |-> !busy_q);

endmodule

`default_nettype wire

/* verilog/cache_top.sv */
`default_nettype none

module cache_top (
  input  wire logic             clk_i,
  input  wire logic             reset_n_i,
  input  wire cache_pkg::addr_t address_i,
  input  wire logic             address_valid_i,
  input  wire cache_pkg::data_t write_data_i,
  input  wire logic             write_data_valid_i,
  input  wire logic             write_i,
  output cache_pkg::data_t      read_data_o,
  output logic                  read_data_valid_o,
  output logic                  write_done_o,
  output logic                  port_ready_o,
  output logic                  hit_o
);

  mem_if mem_bus ();
  array_if arr_bus ();

  cache_ctrl u_ctrl (
    .clk_i              (clk_i),
    .reset_n_i          (reset_n_i),
    .address_i          (address_i),
    .address_valid_i    (address_valid_i),
    .write_data_i       (write_data_i),
    .write_data_valid_i (write_data_valid_i),
    .write_i            (write_i),
    .read_data_o        (read_data_o),
    .read_data_valid_o  (read_data_valid_o),
    .write_done_o       (write_done_o),
    .port_ready_o       (port_ready_o),
    .hit_o              (hit_o),
    .arr                (arr_bus.ctrl),
    .mem                (mem_bus.ctrl)
  );

  cache_array u_array (
    .clk_i     (clk_i),
    .reset_n_i (reset_n_i),
    .arr       (arr_bus.array)
  );

  backing_memory u_memory (
    .clk_i     (clk_i),
    .reset_n_i (reset_n_i),
    .mem       (mem_bus.mem)
  );

endmodule

`default_nettype wire

/* dv/cache_tb.sv */
`default_nettype none

module cache_tb;

  localparam int DRIVE_DELAY = 2;
  localparam int RESET_CYCLES = 16;
  localparam int RANDOM_ACCESSES = 200;
  localparam int NUM_ACCESSES = 10 + RANDOM_ACCESSES;  // directed accesses plus the random mix.
  localparam int ACCESS_BUDGET = cache_pkg::WRITE_LATENCY + cache_pkg::MIN_MISS_CYCLES + 8;
  localparam int TIMEOUT_CYCLES = NUM_ACCESSES * ACCESS_BUDGET + RESET_CYCLES;

  logic clk_i;
  logic reset_n_i;
  cache_pkg::addr_t address_i;
  logic address_valid_i;
  cache_pkg::data_t write_data_i;
  logic write_data_valid_i;
  logic write_i;
  cache_pkg::data_t read_data_o;
  logic read_data_valid_o;
  logic write_done_o;
  logic port_ready_o;
  logic hit_o;

  cache_pkg::data_t ref_mem [cache_pkg::MEM_WORDS];
  cache_pkg::tag_t ref_tag [cache_pkg::NUM_LINES];
  logic ref_valid [cache_pkg::NUM_LINES];
  logic [31:0] rng_state;
  int cycle_count;

  cache_top UUT (
    .clk_i              (clk_i),
    .reset_n_i          (reset_n_i),
    .address_i          (address_i),
    .address_valid_i    (address_valid_i),
    .write_data_i       (write_data_i),
    .write_data_valid_i (write_data_valid_i),
    .write_i            (write_i),
    .read_data_o        (read_data_o),
    .read_data_valid_o  (read_data_valid_o),
    .write_done_o       (write_done_o),
    .port_ready_o       (port_ready_o),
    .hit_o              (hit_o)
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_data(input cache_pkg::data_t got, input cache_pkg::data_t exp,
                            input string what);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s data 0x%04h, expected 0x%04h",
                          $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_cycles(input int got, input int lo, input int hi, input string what);
    if ((got < lo) || (got > hi)) begin
      abort_run($sformatf("Mismatch at %0t: %s took %0d cycles, expected %0d to %0d",
                          $time, what, got, lo, hi));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic model_hit(input cache_pkg::addr_t addr);
    cache_pkg::index_t idx;
    idx = addr[cache_pkg::INDEX_W-1:0];
    return ref_valid[idx] && (ref_tag[idx] == addr[cache_pkg::ADDR_W-1:cache_pkg::INDEX_W]);
  endfunction

  // one request from ready to completion, cycles counted from the acceptance edge.
  task automatic run_access(input logic wr, input cache_pkg::addr_t addr,
                            input cache_pkg::data_t wdata, output cache_pkg::data_t rdata,
                            output logic hit, output int cycles);
    while (!port_ready_o) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
    end
    address_i = addr;
    address_valid_i = 1'b1;
    write_data_i = wdata;
    write_data_valid_i = wr;
    write_i = wr;
    @(posedge clk_i);
    #DRIVE_DELAY;
    address_valid_i = 1'b0;
    write_data_valid_i = 1'b0;
    check_bit(port_ready_o, 1'b0, "port_ready_o after acceptance");
    cycles = 0;
    do begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      cycles++;
    end while (!(wr ? write_done_o : read_data_valid_o));
    rdata = read_data_o;
    hit = hit_o;
    check_bit(port_ready_o, 1'b1, "port_ready_o at completion");
    check_bit(wr ? read_data_valid_o : write_done_o, 1'b0, "other completion flag");
  endtask

  task automatic read_check(input cache_pkg::addr_t addr, input logic exp_hit,
                            input string label);
    cache_pkg::data_t rdata;
    logic hit;
    int cycles;
    string what;
    what = $sformatf("%s read of 0x%02h", label, addr);
    run_access(1'b0, addr, '0, rdata, hit, cycles);
    check_bit(hit, exp_hit, {what, " hit_o"});
    check_data(rdata, ref_mem[addr], what);
    if (exp_hit) begin
      check_cycles(cycles, cache_pkg::MIN_HIT_CYCLES, cache_pkg::MIN_HIT_CYCLES, what);
    end else begin
      check_cycles(cycles, cache_pkg::MIN_MISS_CYCLES, ACCESS_BUDGET, what);
      ref_valid[addr[cache_pkg::INDEX_W-1:0]] = 1'b1;  // a read miss fills the line.
      ref_tag[addr[cache_pkg::INDEX_W-1:0]] = addr[cache_pkg::ADDR_W-1:cache_pkg::INDEX_W];
    end
  endtask

  task automatic write_check(input cache_pkg::addr_t addr, input cache_pkg::data_t wdata,
                             input logic exp_hit, input string label);
    cache_pkg::data_t rdata;
    logic hit;
    int cycles;
    string what;
    what = $sformatf("%s write of 0x%02h", label, addr);
    run_access(1'b1, addr, wdata, rdata, hit, cycles);
    check_bit(hit, exp_hit, {what, " hit_o"});
    check_cycles(cycles, cache_pkg::MIN_MISS_CYCLES, ACCESS_BUDGET, what);
    ref_mem[addr] = wdata;  // memory always takes the write, the line map stays as it is.
  endtask

  task automatic test_reset_state();
    check_bit(port_ready_o, 1'b1, "port_ready_o after reset");
    check_bit(read_data_valid_o, 1'b0, "read_data_valid_o after reset");
    check_bit(write_done_o, 1'b0, "write_done_o after reset");
    check_bit(hit_o, 1'b0, "hit_o after reset");
  endtask

  task automatic test_miss_then_hit();
    read_check(8'h2A, 1'b0, "miss then hit");
    read_check(8'h2A, 1'b1, "miss then hit");
  endtask

  task automatic test_no_write_allocate();
    write_check(8'h73, 16'h5A5A, 1'b0, "no allocate");
    read_check(8'h73, 1'b0, "no allocate");
    read_check(8'h73, 1'b1, "no allocate");
  endtask

  task automatic test_write_through();
    read_check(8'h15, 1'b0, "write through");
    write_check(8'h15, 16'hBEEF, 1'b1, "write through");
    read_check(8'h15, 1'b1, "write through");
    read_check(8'h55, 1'b0, "write through");  // same index, evicts 0x15.
    read_check(8'h15, 1'b0, "write through");
  endtask

  task automatic test_random_mix();
    cache_pkg::addr_t addr;
    cache_pkg::data_t wdata;
    logic do_write;
    for (int n = 0; n < RANDOM_ACCESSES; n++) begin
      rng_state = xorshift32(rng_state);
      addr = {4'b0110, rng_state[2:1], 1'b0, rng_state[0]};  // four tags over two indices.
      do_write = (rng_state[15:13] < 3'd3);
      wdata = rng_state[31:16];
      if (do_write) begin
        write_check(addr, wdata, model_hit(addr), "random");
      end else begin
        read_check(addr, model_hit(addr), "random");
      end
    end
  endtask

  initial begin
    clk_i = 1'b0;
    reset_n_i = 1'b0;
    address_i = '0;
    address_valid_i = 1'b0;
    write_data_i = '0;
    write_data_valid_i = 1'b0;
    write_i = 1'b0;
    cycle_count = 0;
    rng_state = 32'd46185;
    for (int i = 0; i < cache_pkg::MEM_WORDS; i++) begin
      ref_mem[i] = '0;
    end
    for (int i = 0; i < cache_pkg::NUM_LINES; i++) begin
      ref_valid[i] = 1'b0;
      ref_tag[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY;
    reset_n_i = 1'b1;
    test_reset_state();
    test_miss_then_hit();
    test_no_write_allocate();
    test_write_through();
    test_random_mix();
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
common/cache_pkg.sv
common/mem_if.sv
common/array_if.sv
cache/cache_array.sv
cache/cache_ctrl.sv
verilog/backing_memory.sv
verilog/cache_top.sv
dv/cache_tb.sv

/* Bender.yml */
package:
  name: cache

sources:
  - files:
      - common/cache_pkg.sv
      - common/mem_if.sv
      - common/array_if.sv
      - cache/cache_array.sv
      - cache/cache_ctrl.sv
      - verilog/backing_memory.sv
      - verilog/cache_top.sv
  - target: test
    files:
      - dv/cache_tb.sv
